//--- files.f
rob_pkg.sv
commit_arbiter.sv
branch_resolver.sv
reorder_buffer.sv
rob_top.sv
tb_rob_checker.sv
tb_rob.sv

//--- Makefile
VERILATOR  = verilator
FLAGS      = --binary --timing
LINT_FLAGS = --lint-only --timing
TOP        = tb_rob
FILELIST   = files.f
PASS_TEXT  = No errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module rob_top rob_pkg.sv commit_arbiter.sv \
		branch_resolver.sv reorder_buffer.sv rob_top.sv

clean:
	rm -rf obj_dir

//--- tb_rob.sv
module tb_rob;

  localparam int SIZE = 8;
  localparam int NUM_INSTR = 400;
  localparam int CYCLE_LIMIT = NUM_INSTR * 8 + 500;

  typedef struct packed {
    logic [rob_pkg::tag_w-1:0] tag;
    rob_pkg::instr_kind_e      kind;
    logic [31:0]               pc;
    logic [31:0]               pred;
  } outstanding_t;

  logic                      global_bus;
  logic                      rst_n;
  rob_pkg::issue_req_t       issue     [2];
  logic [rob_pkg::tag_w-1:0] issue_tag [2];
  logic                      full;
  rob_pkg::result_t          result    [2];
  logic [1:0]                lane_busy;
  rob_pkg::commit_t          commit    [2];
  rob_pkg::redirect_t        redirect;

  int   errors;
  int   commits;
  int   flushes;
  logic idle;
  int   accepted;
  int   cycles;

  logic [15:0]  lfsr;
  outstanding_t waiting[$];

  rob_top #(.SIZE(SIZE)) uut (
    .global_bus (global_bus),
    .rst_n      (rst_n),
    .issue      (issue),
    .issue_tag  (issue_tag),
    .full       (full),
    .result     (result),
    .lane_busy  (lane_busy),
    .commit     (commit),
    .redirect   (redirect)
  );

  tb_rob_checker #(.SIZE(SIZE)) chk (
    .global_bus (global_bus),
    .rst_n      (rst_n),
    .issue      (issue),
    .issue_tag  (issue_tag),
    .full       (full),
    .result     (result),
    .lane_busy  (lane_busy),
    .commit     (commit),
    .redirect   (redirect),
    .errors     (errors),
    .commits    (commits),
    .flushes    (flushes),
    .idle       (idle)
  );

  // a 16 bit Fibonacci LFSR steps once per bit handed out
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      r    = {r[30:0], fb};
    end
    return r;
  endfunction

  initial begin
    global_bus = 1'b0;
  end

  always #20 global_bus = ~global_bus;

  always @(posedge global_bus) begin : drive
    rob_pkg::issue_req_t req;
    rob_pkg::result_t    res;
    outstanding_t        o;
    int                  idx;
    if (rst_n) begin
      // everything still waiting for a result was flushed by the mispredict
      if (redirect.valid) begin
        waiting.delete();
      end
      if (!full) begin
        for (int l = 0; l < 2; l++) begin
          if (issue[l].valid) begin
            o.tag  = issue_tag[l];
            o.kind = issue[l].kind;
            o.pc   = issue[l].pc;
            o.pred = issue[l].predicted_target;
            waiting.push_back(o);
            accepted++;
          end
        end
      end
      for (int r = 0; r < 2; r++) begin
        res = '0;
        if (waiting.size() > 0 && rand_bits(1) == 1) begin
          idx = int'(rand_bits(8)) % waiting.size();
          o = waiting[idx];
          waiting.delete(idx);
          res.valid  = 1'b1;
          res.tag    = o.tag;
          res.value  = {o.pc[31:4], o.tag} ^ 32'h0bad_f00d;
          res.target = o.pred;
          if (o.kind != rob_pkg::BRANCH || rand_bits(2) == 0) begin
            res.target = rand_bits(30) << 2;
          end
        end
        result[r] <= res;
      end
      for (int l = 0; l < 2; l++) begin
        req = '0;
        if (accepted < NUM_INSTR) begin
          req.valid = 1'(rand_bits(1));
          req.kind  = rob_pkg::instr_kind_e'(rand_bits(2));
          req.pc    = rand_bits(30) << 2;
          req.rd    = 5'(rand_bits(5));
          req.predicted_target = req.pc + 32'd4;
          if (req.kind == rob_pkg::BRANCH && rand_bits(1) == 1) begin
            req.predicted_target = req.pc + (rand_bits(10) << 2);
          end
        end
        issue[l] <= req;
      end
      lane_busy[0] <= rand_bits(2) == 0;
      lane_busy[1] <= rand_bits(2) == 0;
    end
  end

  always @(posedge global_bus) begin
    cycles <= cycles + 1;
    if (cycles == CYCLE_LIMIT) begin
      $display("timeout: the buffer did not drain within %0d cycles", CYCLE_LIMIT);
      $display("Errors found");
      $finish;
    end
  end

  initial begin
    lfsr      = 16'd81;
    rst_n     = 1'b0;
    accepted  = 0;
    cycles    = 0;
    issue[0]  = '0;
    issue[1]  = '0;
    result[0] = '0;
    result[1] = '0;
    lane_busy = 2'b00;
    repeat (16) @(posedge global_bus);
    rst_n <= 1'b1;
    wait (accepted >= NUM_INSTR && idle);
    repeat (4) @(posedge global_bus);
    $display("issued %0d committed %0d redirects %0d errors %0d",
             accepted, commits, flushes, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

//--- tb_rob_checker.sv
module tb_rob_checker #(
  parameter int SIZE = 8
) (
  input  logic                      global_bus,
  input  logic                      rst_n,
  input  rob_pkg::issue_req_t       issue     [2],
  input  logic [rob_pkg::tag_w-1:0] issue_tag [2],
  input  logic                      full,
  input  rob_pkg::result_t          result    [2],
  input  logic [1:0]                lane_busy,
  input  rob_pkg::commit_t          commit    [2],
  input  rob_pkg::redirect_t        redirect,
  output int                        errors,
  output int                        commits,
  output int                        flushes,
  output logic                      idle
);

  typedef struct packed {
    logic [rob_pkg::tag_w-1:0] tag;
    rob_pkg::instr_kind_e      kind;
    logic [31:0]               pc;
    logic [4:0]                rd;
    logic [31:0]               pred;
    logic [31:0]               value;
    logic [31:0]               target;
    logic                      done;
  } entry_t;

  // program order model, plus the issues of the last edge that a flush may still drop
  entry_t     model[$];
  entry_t     fresh[$];
  int         tail;
  logic [1:0] prev_busy;

  initial begin
    errors  = 0;
    commits = 0;
    flushes = 0;
    idle    = 1'b1;
  end

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic complain(input string what);
    $display("%s", what);
    errors++;
  endtask

  always @(posedge global_bus) begin : watch
    entry_t      e;
    logic        expect_redirect;
    logic [31:0] branch_target;
    int          branch_tag;
    if (!rst_n) begin
      model.delete();
      fresh.delete();
      tail      = 0;
      prev_busy = 2'b00;
    end else begin
      expect_redirect = 1'b0;
      branch_target   = '0;
      branch_tag      = 0;
      if (commit[0].valid && commit[1].valid) begin
        complain("both commit lanes were valid in the same cycle");
      end
      for (int l = 0; l < 2; l++) begin
        if (commit[l].valid) begin
          commits++;
          if (prev_busy[l]) begin
            complain($sformatf("commit appeared on busy lane %0d", l));
          end
          if (model.size() == 0) begin
            complain("commit appeared while no instruction was outstanding");
          end else begin
            e = model.pop_front();
            if (!e.done) begin
              complain("an instruction committed before its result came back");
            end
            compare_value("commit.tag", 32'(commit[l].tag), 32'(e.tag));
            compare_value("commit.pc", commit[l].pc, e.pc);
            compare_value("commit.rd", 32'(commit[l].rd), 32'(e.rd));
            compare_value("commit.value", commit[l].value, e.value);
            compare_value("commit.reg_write", 32'(commit[l].reg_write),
                          32'(e.kind == rob_pkg::ALU || e.kind == rob_pkg::LOAD));
            compare_value("commit.mem_write", 32'(commit[l].mem_write),
                          32'(e.kind == rob_pkg::STORE));
            if (e.kind == rob_pkg::BRANCH && e.target != e.pred) begin
              expect_redirect = 1'b1;
              branch_target   = e.target;
              branch_tag      = int'(e.tag);
            end
          end
        end
      end
      compare_value("redirect.valid", 32'(redirect.valid), 32'(expect_redirect));
      if (redirect.valid && expect_redirect) begin
        compare_value("redirect.target", redirect.target, branch_target);
      end
      if (expect_redirect) begin
        // everything younger than the branch is gone, including last edge's issues
        flushes++;
        model.delete();
        fresh.delete();
        tail = (branch_tag + 1) % SIZE;
      end else begin
        foreach (fresh[i]) begin
          model.push_back(fresh[i]);
        end
        tail = (tail + fresh.size()) % SIZE;
        fresh.delete();
      end
      for (int r = 0; r < 2; r++) begin
        if (result[r].valid) begin
          foreach (model[i]) begin
            if (model[i].tag == result[r].tag) begin
              model[i].value  = result[r].value;
              model[i].target = result[r].target;
              model[i].done   = 1'b1;
            end
          end
        end
      end
      compare_value("full", 32'(full), 32'(model.size() > SIZE - 2));
      compare_value("issue_tag[0]", 32'(issue_tag[0]), 32'(tail));
      compare_value("issue_tag[1]", 32'(issue_tag[1]),
                    32'((tail + (issue[0].valid ? 1 : 0)) % SIZE));
      if (!full) begin
        for (int l = 0; l < 2; l++) begin
          if (issue[l].valid) begin
            e        = '0;
            e.tag    = rob_pkg::tag_w'((tail + ((l == 1 && issue[0].valid) ? 1 : 0)) % SIZE);
            e.kind   = issue[l].kind;
            e.pc     = issue[l].pc;
            e.rd     = issue[l].rd;
            e.pred   = issue[l].predicted_target;
            fresh.push_back(e);
          end
        end
      end
      prev_busy = lane_busy;
      idle      = model.size() == 0 && fresh.size() == 0;
    end
  end

endmodule

//--- rob_top.sv
module rob_top #(
  parameter int SIZE = 16
) (
  input  logic                        global_bus,
  input  logic                        rst_n,
  input  rob_pkg::issue_req_t         issue     [2],
  output logic [rob_pkg::tag_w-1:0]   issue_tag [2],
  output logic                        full,
  input  rob_pkg::result_t            result    [2],
  input  logic [1:0]                  lane_busy,
  output rob_pkg::commit_t            commit    [2],
  output rob_pkg::redirect_t          redirect
);

  // the buffer holds the arbiter and the branch resolver
  reorder_buffer #(
    .SIZE (SIZE)
  ) rob (
    .global_bus (global_bus),
    .rst_n      (rst_n),
    .issue      (issue),
    .issue_tag  (issue_tag),
    .full       (full),
    .result     (result),
    .lane_busy  (lane_busy),
    .commit     (commit),
    .redirect   (redirect)
  );

endmodule

//--- reorder_buffer.sv
module reorder_buffer #(
  parameter int SIZE = 16
) (
  input  logic                        global_bus,
  input  logic                        rst_n,
  input  rob_pkg::issue_req_t         issue     [2],
  output logic [rob_pkg::tag_w-1:0]   issue_tag [2],
  output logic                        full,
  input  rob_pkg::result_t            result    [2],
  input  logic [1:0]                  lane_busy,
  output rob_pkg::commit_t            commit    [2],
  output rob_pkg::redirect_t          redirect
);

  localparam int idx_w = $clog2(SIZE);
  localparam int cnt_w = $clog2(SIZE + 1);

  rob_pkg::entry_status_e    status      [SIZE];
  rob_pkg::instr_kind_e      kind        [SIZE];
  logic [rob_pkg::xlen-1:0]  pc          [SIZE];
  logic [4:0]                rd          [SIZE];
  logic [rob_pkg::xlen-1:0]  pred_target [SIZE];
  logic [rob_pkg::xlen-1:0]  value       [SIZE];
  logic [rob_pkg::xlen-1:0]  res_target  [SIZE];

  logic [idx_w-1:0] head;
  logic [idx_w-1:0] tail;
  logic [cnt_w-1:0] count;

  logic [idx_w-1:0] slot      [2];
  logic [idx_w-1:0] res_idx   [2];
  logic [1:0]       take;
  logic [1:0]       res_hit;
  logic [1:0]       lane_sel;
  logic             request;
  logic             grant;
  logic             lane;
  logic             mispredict;

  function automatic logic [rob_pkg::tag_w-1:0] to_tag(input logic [idx_w-1:0] p);
    logic [rob_pkg::tag_w-1:0] t;
    t = '0;
    t[idx_w-1:0] = p;
    return t;
  endfunction

  // fewer than two free slots blocks the whole issue pair
  assign full = count > cnt_w'(SIZE - 2);

  // lane 1 takes the slot after lane 0 only when lane 0 issues as well
  assign slot[0] = tail;
  assign slot[1] = issue[0].valid ? tail + idx_w'(1) : tail;
  assign issue_tag[0] = to_tag(slot[0]);
  assign issue_tag[1] = to_tag(slot[1]);

  // a redirect drops whatever tries to issue in the same cycle
  assign take[0] = issue[0].valid && !full && !mispredict;
  assign take[1] = issue[1].valid && !full && !mispredict;

  always_comb begin
    for (int r = 0; r < 2; r++) begin
      res_idx[r] = result[r].tag[idx_w-1:0];
      res_hit[r] = result[r].valid && status[res_idx[r]] != rob_pkg::FREE;
    end
  end

  assign request  = status[head] == rob_pkg::COMPLETED;
  assign lane_sel = {grant & lane, grant & ~lane};

  commit_arbiter arbiter (
    .global_bus (global_bus),
    .rst_n      (rst_n),
    .request    (request),
    .lane_busy  (lane_busy),
    .grant      (grant),
    .lane       (lane)
  );

  branch_resolver resolver (
    .global_bus       (global_bus),
    .rst_n            (rst_n),
    .retire           (grant),
    .head_kind        (kind[head]),
    .predicted_target (pred_target[head]),
    .resolved_target  (res_target[head]),
    .mispredict       (mispredict),
    .redirect         (redirect)
  );

  always_ff @(posedge global_bus or negedge rst_n) begin
    if (!rst_n) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else if (mispredict) begin
      // the branch leaves and everything younger is gone, so the buffer empties
      head  <= head + idx_w'(1);
      tail  <= head + idx_w'(1);
      count <= '0;
    end else begin
      head  <= head + idx_w'(grant);
      tail  <= tail + idx_w'(take[0]) + idx_w'(take[1]);
      count <= count + cnt_w'(take[0]) + cnt_w'(take[1]) - cnt_w'(grant);
    end
  end

  // later assignments win, so a flush overrides everything else
  always_ff @(posedge global_bus or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < SIZE; i++) begin
        status[i] <= rob_pkg::FREE;
      end
    end else begin
      for (int r = 0; r < 2; r++) begin
        if (res_hit[r]) begin
          status[res_idx[r]] <= rob_pkg::COMPLETED;
        end
      end
      for (int l = 0; l < 2; l++) begin
        if (take[l]) begin
          status[slot[l]] <= rob_pkg::WAITING;
        end
      end
      if (grant) begin
        status[head] <= rob_pkg::FREE;
      end
      if (mispredict) begin
        for (int i = 0; i < SIZE; i++) begin
          status[i] <= rob_pkg::FREE;
        end
      end
    end
  end

  always_ff @(posedge global_bus) begin
    for (int l = 0; l < 2; l++) begin
      if (take[l]) begin
        kind[slot[l]]        <= issue[l].kind;
        pc[slot[l]]          <= issue[l].pc;
        rd[slot[l]]          <= issue[l].rd;
        pred_target[slot[l]] <= issue[l].predicted_target;
      end
    end
    for (int r = 0; r < 2; r++) begin
      if (res_hit[r]) begin
        value[res_idx[r]]      <= result[r].value;
        res_target[res_idx[r]] <= result[r].target;
      end
    end
  end

  always_ff @(posedge global_bus or negedge rst_n) begin
    if (!rst_n) begin
      commit[0].valid <= 1'b0;
      commit[1].valid <= 1'b0;
    end else begin
      for (int l = 0; l < 2; l++) begin
        commit[l].valid <= lane_sel[l];
        if (lane_sel[l]) begin
          commit[l].tag       <= to_tag(head);
          commit[l].pc        <= pc[head];
          commit[l].rd        <= rd[head];
          commit[l].value     <= value[head];
          commit[l].reg_write <= kind[head] == rob_pkg::ALU || kind[head] == rob_pkg::LOAD;
          commit[l].mem_write <= kind[head] == rob_pkg::STORE;
        end
      end
    end
  end

endmodule

//--- branch_resolver.sv
module branch_resolver (
  input  logic                     global_bus,
  input  logic                     rst_n,
  input  logic                     retire,
  input  rob_pkg::instr_kind_e     head_kind,
  input  logic [rob_pkg::xlen-1:0] predicted_target,
  input  logic [rob_pkg::xlen-1:0] resolved_target,
  output logic                     mispredict,
  output rob_pkg::redirect_t       redirect
);

  logic is_branch;
  logic target_differs;

  assign is_branch      = head_kind == rob_pkg::BRANCH;
  assign target_differs = predicted_target != resolved_target;

  // the buffer flushes on this in the same cycle the branch retires
  assign mispredict = retire && is_branch && target_differs;

  always_ff @(posedge global_bus or negedge rst_n) begin
    if (!rst_n) begin
      redirect.valid <= 1'b0;
    end else begin
      redirect.valid <= mispredict;
      if (mispredict) begin
        redirect.target <= resolved_target;
      end
    end
  end

endmodule

//--- commit_arbiter.sv
module commit_arbiter (
  input  logic       global_bus,
  input  logic       rst_n,
  input  logic       request,
  input  logic [1:0] lane_busy,
  output logic       grant,
  output logic       lane
);

  logic last_lane;

  assign grant = request && !(&lane_busy);

  // with both lanes free the one not used last time wins
  always_comb begin
    if (lane_busy[0]) begin
      lane = 1'b1;
    end else if (lane_busy[1]) begin
      lane = 1'b0;
    end else begin
      lane = ~last_lane;
    end
  end

  always_ff @(posedge global_bus or negedge rst_n) begin
    if (!rst_n) begin
      // lane 0 gets the first grant after reset
      last_lane <= 1'b1;
    end else if (grant) begin
      last_lane <= lane;
    end
  end

endmodule

//--- rob_pkg.sv
package rob_pkg;

  localparam int xlen = 32;

  // slot tags cover a buffer of at most 16 entries
  localparam int tag_w = 4;

  // opcode class, which decides the register and memory write flags at commit
  typedef enum logic [1:0] {
    ALU,
    LOAD,
    STORE,
    BRANCH
  } instr_kind_e;

  typedef enum logic [1:0] {
    FREE,
    WAITING,
    COMPLETED
  } entry_status_e;

  typedef struct packed {
    logic            valid;
    instr_kind_e     kind;
    logic [xlen-1:0] pc;
    logic [4:0]      rd;
    logic [xlen-1:0] predicted_target;
  } issue_req_t;

  // target is the resolved next pc, only meaningful for a branch
  typedef struct packed {
    logic             valid;
    logic [tag_w-1:0] tag;
    logic [xlen-1:0]  value;
    logic [xlen-1:0]  target;
  } result_t;

  typedef struct packed {
    logic             valid;
    logic [tag_w-1:0] tag;
    logic [xlen-1:0]  pc;
    logic [4:0]       rd;
    logic [xlen-1:0]  value;
    logic             reg_write;
    logic             mem_write;
  } commit_t;

  typedef struct packed {
    logic            valid;
    logic [xlen-1:0] target;
  } redirect_t;

endpackage
